/* Bender.yml */
package:
  name: aes_core

sources:
  - logic/aes_pkg.sv
  - logic/aes_sbox.sv
  - logic/aes_round_transform.sv
  - logic/aes_add_round_key.sv
  - logic/aes_key_schedule.sv
  - logic/aes_round_ctrl.sv
  - logic/aes_core.sv
  - target: test
    files:
      - verif/aes_core_tb.sv

/* logic/aes_add_round_key.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cipher state register with the round key XOR
// load takes plaintext ^ key, step takes round_out ^ round_key
// holds otherwise, so state is also the ciphertext
// load and step must be exclusive
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module aes_add_round_key
(
    input  logic            clk,
    input  logic            resetn,
    input  logic            load,
    input  logic            step,
    input  aes_pkg::block_t plaintext,
    input  aes_pkg::block_t key,
    input  aes_pkg::block_t round_key,
    input  aes_pkg::block_t round_out,
    output aes_pkg::block_t state
);

    import aes_pkg::*;

    block_t state_q;
    block_t state_d;

    // load mux in front of the key xor
    always_comb
    begin
        state_d = state_q;                      // hold
        if (load)
            state_d = plaintext ^ key;          // initial round, cipher key
        else if (step)
            state_d = round_out ^ round_key;    // rounds 1 to 10
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state_q <= '0;
        else
            state_q <= state_d;
    end

    assign state = state_q;

    // controller never overlaps the initial add with a round
    a_load_step_excl : assert property
    (
        @(posedge clk) disable iff (!resetn)
        !(load && step)
    );

endmodule

/* logic/aes_core.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// iterative AES-128 encryption, one round per clock
// key and plaintext sampled only on an accepted start
// done 10 cycles after the start edge
// ciphertext held until the next accepted start
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module aes_core
(
    input  logic            clk,
    input  logic            resetn,
    input  logic            start,
    input  aes_pkg::block_t key,
    input  aes_pkg::block_t plaintext,
    output logic            busy,
    output logic            done,
    output aes_pkg::block_t ciphertext
);

    import aes_pkg::*;

    logic       load;
    logic       step;
    logic       last_round;
    round_idx_t round;
    block_t     round_key;      // next round key from the schedule
    block_t     state;          // cipher state register output
    block_t     round_out;      // state after sub/shift/mix

    aes_round_ctrl u_ctrl
    (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .load       (load),
        .step       (step),
        .last_round (last_round),
        .busy       (busy),
        .done       (done),
        .round      (round)
    );

    aes_key_schedule u_key_schedule
    (
        .clk       (clk),
        .resetn    (resetn),
        .load      (load),
        .step      (step),
        .key       (key),
        .round_key (round_key)
    );

    aes_add_round_key u_add_round_key
    (
        .clk       (clk),
        .resetn    (resetn),
        .load      (load),
        .step      (step),
        .plaintext (plaintext),
        .key       (key),
        .round_key (round_key),
        .round_out (round_out),
        .state     (state)
    );

    aes_round_transform u_round_transform
    (
        .state      (state),
        .last_round (last_round),
        .round_out  (round_out)
    );

    assign ciphertext = state;      // valid from done onwards

    // an accepted start puts the core into round 1 on the next cycle
    a_start_round1 : assert property
    (
        @(posedge clk) disable iff (!resetn)
        (start && !busy) |=> (busy && round == round_idx_t'(1))
    );

endmodule

/* logic/aes_key_schedule.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// on the fly AES-128 key expansion, one round key per step
// round_key is the next key, combinational from the register
// key register updates on the same edges as the state register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module aes_key_schedule
(
    input  logic            clk,
    input  logic            resetn,
    input  logic            load,
    input  logic            step,
    input  aes_pkg::block_t key,
    output aes_pkg::block_t round_key
);

    import aes_pkg::*;

    block_t key_q;          // current round key
    byte_t  rcon_q;         // round constant for the next expansion
    word_t  rot_w;          // RotWord of the last column
    word_t  sub_w;          // SubWord of rot_w
    word_t  temp_w;
    word_t  n0;
    word_t  n1;
    word_t  n2;
    word_t  n3;

    assign rot_w = {key_q[23:0], key_q[31:24]};     // w3 rotated one byte left

    for (genvar i = 0; i < 4; i++)
    begin : g_subword
        aes_sbox u_sbox
        (
            .in  (rot_w[31 - 8*i -: 8]),
            .out (sub_w[31 - 8*i -: 8])
        );
    end

    assign temp_w = sub_w ^ {rcon_q, 24'h0};        // rcon only hits the top byte

    // chained column xors, w0 is the msb word
    assign n0 = key_q[127:96] ^ temp_w;
    assign n1 = key_q[95:64]  ^ n0;
    assign n2 = key_q[63:32]  ^ n1;
    assign n3 = key_q[31:0]   ^ n2;

    assign round_key = {n0, n1, n2, n3};

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            key_q  <= '0;
            rcon_q <= 8'h01;
        end
        else if (load)
        begin
            key_q  <= key;          // cipher key is round key 0
            rcon_q <= 8'h01;
        end
        else if (step)
        begin
            key_q  <= round_key;
            rcon_q <= xtime(rcon_q);  // 01 02 04 .. 80 1b 36
        end
    end

    // every step uses one of the ten AES-128 constants, never zero
    // an eleventh step without a load would run past 0x36
    a_rcon_valid : assert property
    (
        @(posedge clk) disable iff (!resetn)
        step |-> (rcon_q inside {8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
                                 8'h20, 8'h40, 8'h80, 8'h1b, 8'h36})
    );

endmodule

/* logic/aes_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types and constants for the AES-128 encryption core
// block byte 0 is the most significant byte, as in FIPS-197
// fixed to AES-128 only, no 192/256 key sizes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package aes_pkg;

    typedef logic [127:0] block_t;      // plaintext, ciphertext, state, round key
    typedef logic [7:0]   byte_t;       // GF(2^8) element
    typedef logic [31:0]  word_t;       // key schedule column
    typedef logic [3:0]   round_idx_t;  // round counter, 0 to 10

    // number of full rounds after the initial key add
    localparam round_idx_t NUM_ROUNDS = 4'd10;

    // control phases
    // LOAD only ever lives in the combinational phase, never in the register
    typedef enum logic [1:0]
    {
        IDLE  = 2'd0,
        LOAD  = 2'd1,
        ROUND = 2'd2
    } ctrl_state_t;

    // multiply by x in GF(2^8), reduction poly x^8+x^4+x^3+x+1
    function automatic byte_t xtime(byte_t b);
        byte_t r;
        r = {b[6:0], 1'b0};
        if (b[7])
            r = r ^ 8'h1b;              // fold the overflow bit back in
        return r;
    endfunction

endpackage

/* logic/aes_round_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequencer for the iterative core
// load is combinational on an idle start, then ten steps
// start while busy is dropped, done is a registered pulse
// done cycle already accepts the next start
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module aes_round_ctrl
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    output logic                load,
    output logic                step,
    output logic                last_round,
    output logic                busy,
    output logic                done,
    output aes_pkg::round_idx_t round
);

    import aes_pkg::*;

    ctrl_state_t state_q;       // holds IDLE or ROUND
    ctrl_state_t phase;         // state as seen this cycle, LOAD folded in
    round_idx_t  round_q;       // round being computed, 0 when idle
    logic        done_q;

    // an idle start turns this cycle into the load cycle
    always_comb
    begin
        phase = state_q;
        if (state_q == IDLE && start)
            phase = LOAD;
    end

    assign load       = (phase == LOAD);
    assign step       = (phase == ROUND);
    assign last_round = step && (round_q == NUM_ROUNDS);   // no MixColumns
    assign busy       = (state_q == ROUND);
    assign done       = done_q;
    assign round      = round_q;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state_q <= IDLE;
            round_q <= '0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= last_round;           // high the cycle after E10
            case (phase)
                LOAD:
                begin
                    state_q <= ROUND;
                    round_q <= round_idx_t'(1);
                end
                ROUND:
                begin
                    if (last_round)
                    begin
                        state_q <= IDLE;
                        round_q <= '0;
                    end
                    else
                        round_q <= round_q + round_idx_t'(1);
                end
                default: ;                  // idle, nothing moves
            endcase
        end
    end

    a_done_pulse : assert property (@(posedge clk) disable iff (!resetn) done |=> !done);
    a_done_idle  : assert property (@(posedge clk) disable iff (!resetn) done |-> !busy);
    a_round_max  : assert property (@(posedge clk) disable iff (!resetn) round_q <= NUM_ROUNDS);

endmodule

/* logic/aes_round_transform.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one AES round without the key add
// SubBytes, ShiftRows, then MixColumns unless last_round
// zero cycles, the whole round is one combinational cloud
// byte i sits at row i%4, column i/4
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module aes_round_transform
(
    input  aes_pkg::block_t state,
    input  logic            last_round,
    output aes_pkg::block_t round_out
);

    import aes_pkg::*;

    byte_t sub_b [16];          // after SubBytes
    byte_t shf_b [16];          // after ShiftRows
    byte_t mix_b [16];          // after MixColumns

    // sixteen parallel S-boxes
    for (genvar i = 0; i < 16; i++)
    begin : g_sbox
        aes_sbox u_sbox
        (
            .in  (state[127 - 8*i -: 8]),
            .out (sub_b[i])
        );
    end

    // row r moves left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                shf_b[4*c + r] = sub_b[4*((c + r) % 4) + r];
        end
    end

    // column mix with the fixed 02 03 01 01 circulant
    always_comb
    begin
        byte_t s0;
        byte_t s1;
        byte_t s2;
        byte_t s3;
        for (int c = 0; c < 4; c++)
        begin
            s0 = shf_b[4*c];
            s1 = shf_b[4*c + 1];
            s2 = shf_b[4*c + 2];
            s3 = shf_b[4*c + 3];
            mix_b[4*c]     = xtime(s0) ^ xtime(s1) ^ s1 ^ s2 ^ s3;    // 2a+3b+c+d
            mix_b[4*c + 1] = s0 ^ xtime(s1) ^ xtime(s2) ^ s2 ^ s3;    // a+2b+3c+d
            mix_b[4*c + 2] = s0 ^ s1 ^ xtime(s2) ^ xtime(s3) ^ s3;    // a+b+2c+3d
            mix_b[4*c + 3] = xtime(s0) ^ s0 ^ s1 ^ s2 ^ xtime(s3);    // 3a+b+c+2d
        end
    end

    // final round skips the column mix
    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            if (last_round)
                round_out[127 - 8*i -: 8] = shf_b[i];
            else
                round_out[127 - 8*i -: 8] = mix_b[i];
        end
    end

endmodule

/* logic/aes_sbox.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// forward AES S-box, purely combinational
// inverse done as x^254 in GF(2^8), so 0 maps to 0 as required
// long logic path, one instance per byte
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module aes_sbox
(
    input  aes_pkg::byte_t in,
    output aes_pkg::byte_t out
);

    import aes_pkg::*;

    // shift-and-add multiply in GF(2^8)
    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t acc;
        byte_t aa;
        acc = '0;
        aa  = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ aa;
            aa = xtime(aa);             // next power of x times a
        end
        return acc;
    endfunction

    function automatic byte_t gf_sq(byte_t a);
        return gf_mul(a, a);
    endfunction

    byte_t x2;      // x^2
    byte_t x3;      // x^3
    byte_t x12;     // x^12
    byte_t x14;     // x^14
    byte_t x15;     // x^15
    byte_t x240;    // x^240
    byte_t inv;     // x^254 == x^-1 for nonzero x

    // addition chain for 254 = 240 + 14
    always_comb
    begin
        x2   = gf_sq(in);
        x3   = gf_mul(x2, in);
        x12  = gf_sq(gf_sq(x3));
        x14  = gf_mul(x12, x2);
        x15  = gf_mul(x12, x3);
        x240 = gf_sq(gf_sq(gf_sq(gf_sq(x15))));
        inv  = gf_mul(x240, x14);
    end

    // affine map, b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 0x63
    assign out = inv
               ^ {inv[6:0], inv[7]}
               ^ {inv[5:0], inv[7:6]}
               ^ {inv[4:0], inv[7:5]}
               ^ {inv[3:0], inv[7:4]}
               ^ 8'h63;

endmodule

/* tb.f */
logic/aes_pkg.sv
logic/aes_sbox.sv
logic/aes_round_transform.sv
logic/aes_add_round_key.sv
logic/aes_key_schedule.sv
logic/aes_round_ctrl.sv
logic/aes_core.sv
verif/aes_core_tb.sv

/* verif/aes_core_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the AES-128 core
// known answers from FIPS-197 plus the all-zero vector
// checks are concurrent assertions, first failure stops the run
// random gaps and scrambles from a 16-bit Galois LFSR
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module aes_core_tb;

    import aes_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_VECS        = 3;
    localparam int NUM_JOBS        = 12;   // modes cycle every NUM_VECS jobs
    localparam int WATCHDOG_CYCLES = NUM_JOBS * (NUM_ROUNDS + 10) + 20;

    logic   clk;
    logic   resetn;
    logic   start;
    block_t key;
    block_t plaintext;
    logic   busy;
    logic   done;
    block_t ciphertext;

    // known-answer table
    block_t vec_key [NUM_VECS] = '{128'h2b7e151628aed2a6abf7158809cf4f3c,
                                   128'h000102030405060708090a0b0c0d0e0f,
                                   128'h0};
    block_t vec_pt  [NUM_VECS] = '{128'h3243f6a8885a308d313198a2e0370734,
                                   128'h00112233445566778899aabbccddeeff,
                                   128'h0};
    block_t vec_ct  [NUM_VECS] = '{128'h3925841d02dc09fbdc118597196a0b32,
                                   128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                                   128'h66e94bd4ef8a2c3b884cfa59ca342b2e};
    string  vec_name [NUM_VECS] = '{"fips197_b", "fips197_c1", "zero_key"};

    block_t      pending_ct;        // expected result of the job being offered
    int          pending_vec;
    block_t      job_ct;            // expected result of the accepted job
    int          job_vec;
    logic        held_valid;        // between done and the next accepted start
    logic        rst_q = 1'b0;      // low in the first cycle after reset
    int          done_count;
    logic [15:0] lfsr = 16'd51;

    aes_core dut
    (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .key        (key),
        .plaintext  (plaintext),
        .busy       (busy),
        .done       (done),
        .ciphertext (ciphertext)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    // x^16+x^14+x^13+x^11+1, one step per bit taken
    function automatic logic [127:0] random_bits(int n);
        logic [127:0] r;
        logic         b;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b)
                lfsr = lfsr ^ 16'hb400;
            r = {r[126:0], b};
        end
        return r;
    endfunction

    task automatic wait_cycle();
        @(posedge clk);
        #2;                         // drive away from the edge
    endtask

    // expected values follow the job that the core actually took
    always @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            rst_q      <= 1'b0;
            job_ct     <= '0;
            job_vec    <= 0;
            held_valid <= 1'b0;
            done_count <= 0;
        end
        else
        begin
            rst_q <= 1'b1;
            if (done)
                done_count <= done_count + 1;
            if (start && !busy)
            begin
                job_ct     <= pending_ct;
                job_vec    <= pending_vec;
                held_valid <= 1'b0;     // new job may overwrite the state
            end
            else if (done)
                held_valid <= 1'b1;
        end
    end

    a_reset_quiet : assert property (@(posedge clk) (!resetn || !rst_q) |-> (!busy && !done))
    else
    begin
        $display("FAIL reset: expected busy=0 done=0, actual busy=%b done=%b",
                 $sampled(busy), $sampled(done));
        abort_run();
    end

    a_known_answer : assert property (@(posedge clk) disable iff (!resetn)
        done |-> (ciphertext == job_ct))
    else
    begin
        $display("FAIL known_answer %s: expected %h actual %h",
                 vec_name[$sampled(job_vec)], $sampled(job_ct), $sampled(ciphertext));
        abort_run();
    end

    // busy for the ten rounds, done right after E10
    a_latency : assert property (@(posedge clk) disable iff (!resetn)
        (start && !busy) |=> (busy && !done) [*10] ##1 (done && !busy))
    else
    begin
        $display("FAIL latency: expected busy=1 until done 10 cycles after start, actual busy=%b done=%b",
                 $sampled(busy), $sampled(done));
        abort_run();
    end

    a_done_pulse : assert property (@(posedge clk) disable iff (!resetn) done |=> !done)
    else
    begin
        $display("FAIL done_pulse: expected done=0 actual done=%b", $sampled(done));
        abort_run();
    end

    // result of the finished job stays on the output until the next accepted start
    a_hold : assert property (@(posedge clk) disable iff (!resetn)
        held_valid |-> (ciphertext == job_ct))
    else
    begin
        $display("FAIL hold %s: expected %h actual %h",
                 vec_name[$sampled(job_vec)], $sampled(job_ct), $sampled(ciphertext));
        abort_run();
    end

    // mode 0 plain, 1 start while busy, 2 inputs scrambled, 3 next start in done cycle
    task automatic run_job(int vec, int mode);
        int k;
        int waited;
        key         = vec_key[vec];
        plaintext   = vec_pt[vec];
        pending_ct  = vec_ct[vec];
        pending_vec = vec;
        start       = 1'b1;
        wait_cycle();               // accepting edge has passed
        start = 1'b0;
        if (mode == 2)
        begin
            key       = random_bits(128);
            plaintext = random_bits(128);
        end
        if (mode == 1)
        begin
            k = 1 + int'(random_bits(2));
            repeat (k) wait_cycle();
            start     = 1'b1;       // must be dropped, core is busy
            key       = random_bits(128);
            plaintext = random_bits(128);
            wait_cycle();
            start = 1'b0;
        end
        waited = 0;
        while (!done)
        begin
            wait_cycle();
            waited++;
            if (waited > 2 * NUM_ROUNDS)
            begin
                $display("no done pulse within %0d cycles of the start", waited);
                abort_run();
            end
        end
    endtask

    initial
    begin
        int mode;
        int gap;
        resetn      = 1'b0;
        start       = 1'b0;
        key         = '0;
        plaintext   = '0;
        pending_ct  = '0;
        pending_vec = 0;
        repeat (3) @(posedge clk);
        #2;
        resetn = 1'b1;
        for (int j = 0; j < NUM_JOBS; j++)
        begin
            mode = (j / NUM_VECS) % 4;
            run_job(j % NUM_VECS, mode);
            if (mode != 3)
            begin
                gap = int'(random_bits(3));     // 0 to 7 idle cycles
                repeat (gap) wait_cycle();
            end
        end
        repeat (4) wait_cycle();                // last done and some hold cycles
        if (done_count == NUM_JOBS)
        begin
            $display(">>> PASS");
            $finish;
        end
        else
        begin
            $display("FAIL done_count: expected %0d actual %0d", NUM_JOBS, done_count);
            abort_run();
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

endmodule
